/* build.f */
+incdir+.
pwo_pkg.sv
pwo_ctrl.sv
pwo_arith.sv
pwo_mem.sv
pwo_ctrl_checks.sv
pwo_top.sv
tb_pwo.sv

/* Makefile */
# Verilator lint, simulation and clean for the pointwise-operation engine

VERILATOR ?= verilator
TOP       ?= tb_pwo
FLIST     ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= Test failed

SHELL := /bin/bash
BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# the log decides the verdict, a crashed run fails through pipefail
sim: build
	set -o pipefail; $(BIN) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_pwo.sv */
//--------------------------------------------------------------------------
// random-stimulus testbench for the pointwise-operation engine with a
// memory mirror as reference model, compare tasks and a cycle watchdog
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "pwo_defines.svh"

module tb_pwo import pwo_pkg::*; ();

  localparam int DEPTH       = 1 << `PWO_ADDR_W;
  localparam int NUM_OPS     = 20;
  localparam int OP_CYCLES   = `PWO_N * 4 + 20;
  // initial fill, one full readback per operation, reset and zeroize
  localparam int LOAD_CYCLES = (NUM_OPS + 4) * (DEPTH + 4);
  localparam int MAX_CYCLES  = NUM_OPS * OP_CYCLES + LOAD_CYCLES;

  logic  pi_clk, pi_reset_n, zeroize, enable, accumulate;
  logic  sampler_valid, host_wr_en, busy, done;
  mode_t mode;
  addr_t base_a, base_b, base_c, host_addr;
  coef_t sampler_data, host_wr_data, host_rd_data;

  coef_t mem_model [DEPTH];
  int    value_errors, other_errors, done_count, completed_ops, cycle_cnt;

  pwo_top pwo_top_i (.*);

  initial begin
    pi_clk = 1'b0;
    forever #4 pi_clk = ~pi_clk;
  end

  // one negedge sees each single-cycle done pulse
  always @(negedge pi_clk) begin
    if (pi_reset_n && done) done_count++;
  end

  always @(posedge pi_clk) begin
    cycle_cnt++;
    if (cycle_cnt > MAX_CYCLES) begin
      $display("run stopped, no end of test after %0d cycles", MAX_CYCLES);
      $display("value errors: %0d, other errors: %0d", value_errors, other_errors + 1);
      $display("Test failed");
      $finish;
    end
  end

  task automatic check_coef(input string name, input coef_t exp, input coef_t act);
    if (act !== exp) begin
      value_errors++;
      $display("Error: %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      value_errors++;
      $display("Error: %s expected %h actual %h", name, exp, act);
    end
  endtask

  function automatic coef_t rand_coef();
    return coef_t'($urandom % 32'(`PWO_Q));
  endfunction

  // pointwise result from the mod-q rules
  function automatic coef_t expect_word(mode_t m, logic acc, coef_t a, coef_t b, coef_t c);
    longint unsigned q, la, lb, lc, r;
    q  = 64'(`PWO_Q);
    la = 64'(a);
    lb = 64'(b);
    lc = 64'(c);
    case (m)
      pwa:     r = (la + lb) % q;
      pws:     r = (la >= lb) ? la - lb : q - (lb - la);
      default: r = acc ? (lc + (la * lb) % q) % q : (la * lb) % q;
    endcase
    return coef_t'(r);
  endfunction

  task automatic load_memory();
    for (int i = 0; i < DEPTH; i++) begin
      host_wr_en   = 1'b1;
      host_addr    = addr_t'(i);
      host_wr_data = rand_coef();
      mem_model[i] = host_wr_data;
      @(negedge pi_clk);
    end
    host_wr_en = 1'b0;
  endtask

  // pipelined host readback, one word per cycle
  task automatic check_all_words();
    host_wr_en = 1'b0;
    host_addr  = '0;
    for (int i = 0; i < DEPTH; i++) begin
      @(negedge pi_clk);
      check_coef($sformatf("host_rd_data[%02h]", i), mem_model[i], host_rd_data);
      host_addr = addr_t'(i + 1);
    end
  endtask

  task automatic start_op(input mode_t m, input logic acc, input addr_t ba, input addr_t bc);
    mode       = m;
    accumulate = acc;
    base_a     = ba;
    base_b     = ba + addr_t'(`PWO_N);
    base_c     = bc;
    enable     = 1'b1;
    @(negedge pi_clk);
    enable = 1'b0;
    check_flag("busy", 1'b1, busy);
  endtask

  task automatic run_op(input mode_t m, input logic acc);
    coef_t samp_q [`PWO_N];
    int    taken;
    addr_t ba, bb, bc;
    coef_t b;
    ba = addr_t'($urandom);
    bb = ba + addr_t'(`PWO_N);
    // in place, or a c range clear of both a and b
    if ($urandom_range(3) == 0) bc = ba;
    else bc = ba + addr_t'(2 * `PWO_N) + addr_t'($urandom_range(`PWO_N));
    start_op(m, acc, ba, bc);
    taken = 0;
    do begin
      sampler_valid = ($urandom_range(2) != 0);
      sampler_data  = rand_coef();
      // taken at the coming posedge while indices remain
      if (busy && sampler_valid && (m == pwm) && (taken < `PWO_N)) begin
        samp_q[taken] = sampler_data;
        taken++;
      end
      @(negedge pi_clk);
    end while (!done);
    sampler_valid = 1'b0;
    check_flag("busy", 1'b0, busy);
    completed_ops++;
    if ((m == pwm) && (taken != `PWO_N)) begin
      other_errors++;
      $display("pwm operation ended after %0d sampler words instead of %0d", taken, `PWO_N);
    end
    for (int i = 0; i < `PWO_N; i++) begin
      b = (m == pwm) ? samp_q[i] : mem_model[addr_t'(bb + addr_t'(i))];
      mem_model[addr_t'(bc + addr_t'(i))] = expect_word(m, acc,
        mem_model[addr_t'(ba + addr_t'(i))], b, mem_model[addr_t'(bc + addr_t'(i))]);
    end
    @(negedge pi_clk);
    check_flag("done", 1'b0, done);
  endtask

  task automatic zeroize_mid_op();
    start_op(pws, 1'b0, addr_t'($urandom), addr_t'($urandom));
    repeat ($urandom_range(40, 5)) @(negedge pi_clk);
    zeroize = 1'b1;
    @(negedge pi_clk);
    zeroize = 1'b0;
    check_flag("busy", 1'b0, busy);
    check_flag("done", 1'b0, done);
    for (int i = 0; i < DEPTH; i++) mem_model[i] = '0;
    check_all_words();
  endtask

  initial begin
    void'($urandom(32'h430c_5d63));
    {pi_reset_n, zeroize, enable, accumulate, sampler_valid, host_wr_en} = '0;
    mode = pwa;
    {base_a, base_b, base_c, host_addr} = '0;
    {sampler_data, host_wr_data} = '0;
    repeat (16) @(negedge pi_clk);
    pi_reset_n = 1'b1;
    @(negedge pi_clk);
    check_flag("busy", 1'b0, busy);
    check_flag("done", 1'b0, done);
    load_memory();
    check_all_words();
    for (int k = 0; k < NUM_OPS; k++) begin
      case (k % 4)
        0:       run_op(pwa, 1'b0);
        1:       run_op(pws, 1'b0);
        2:       run_op(pwm, 1'b0);
        default: run_op(pwm, 1'b1);
      endcase
      check_all_words();
    end
    zeroize_mid_op();
    // the aborted operation gives no done
    if (done_count != completed_ops) begin
      other_errors++;
      $display("%0d done pulses seen for %0d completed operations", done_count, completed_ops);
    end
    $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
    if ((value_errors == 0) && (other_errors == 0)) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* pwo_top.sv */
//--------------------------------------------------------------------------
// pointwise-operation engine top: controller, arithmetic, memory, checks
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "pwo_defines.svh"

module pwo_top import pwo_pkg::*; (
  input  logic  pi_clk,
  input  logic  pi_reset_n,
  input  logic  zeroize,
  input  logic  enable,
  input  mode_t mode,
  input  logic  accumulate,
  input  addr_t base_a,
  input  addr_t base_b,
  input  addr_t base_c,
  input  logic  sampler_valid,
  input  coef_t sampler_data,
  input  logic  host_wr_en,
  input  addr_t host_addr,
  input  coef_t host_wr_data,
  output coef_t host_rd_data,
  output logic  busy,
  output logic  done
);

  logic  rd_en;
  addr_t rd_addr_a;
  addr_t rd_addr_b;
  addr_t rd_addr_c;
  addr_t wr_addr;
  logic  issue_b_sel;
  coef_t rd_data_a;
  coef_t rd_data_b;
  coef_t rd_data_c;
  coef_t result;
  logic  result_valid;

  pwo_ctrl pwo_ctrl_i (
    .pi_clk        (pi_clk),
    .pi_reset_n    (pi_reset_n),
    .zeroize       (zeroize),
    .enable        (enable),
    .mode          (mode),
    .base_a        (base_a),
    .base_b        (base_b),
    .base_c        (base_c),
    .sampler_valid (sampler_valid),
    .rd_en         (rd_en),
    .rd_addr_a     (rd_addr_a),
    .rd_addr_b     (rd_addr_b),
    .rd_addr_c     (rd_addr_c),
    .wr_addr       (wr_addr),
    .issue_b_sel   (issue_b_sel),
    .busy          (busy),
    .done          (done)
  );

  pwo_arith pwo_arith_i (
    .pi_clk       (pi_clk),
    .pi_reset_n   (pi_reset_n),
    .zeroize      (zeroize),
    .mode         (mode),
    .accumulate   (accumulate),
    .rd_en        (rd_en),
    .issue_b_sel  (issue_b_sel),
    .sampler_data (sampler_data),
    .rd_data_a    (rd_data_a),
    .rd_data_b    (rd_data_b),
    .rd_data_c    (rd_data_c),
    .result       (result),
    .result_valid (result_valid)
  );

  // the arithmetic valid is the memory write strobe
  pwo_mem pwo_mem_i (
    .pi_clk       (pi_clk),
    .pi_reset_n   (pi_reset_n),
    .zeroize      (zeroize),
    .rd_en        (rd_en),
    .rd_addr_a    (rd_addr_a),
    .rd_addr_b    (rd_addr_b),
    .rd_addr_c    (rd_addr_c),
    .wr_en        (result_valid),
    .wr_addr      (wr_addr),
    .result       (result),
    .host_wr_en   (host_wr_en),
    .host_addr    (host_addr),
    .host_wr_data (host_wr_data),
    .busy         (busy),
    .rd_data_a    (rd_data_a),
    .rd_data_b    (rd_data_b),
    .rd_data_c    (rd_data_c),
    .host_rd_data (host_rd_data)
  );

  pwo_ctrl_checks pwo_ctrl_checks_i (
    .pi_clk        (pi_clk),
    .pi_reset_n    (pi_reset_n),
    .zeroize       (zeroize),
    .enable        (enable),
    .mode          (mode),
    .accumulate    (accumulate),
    .sampler_valid (sampler_valid),
    .rd_en         (rd_en),
    .wr_en         (result_valid),
    .busy          (busy),
    .done          (done)
  );

endmodule

/* pwo_ctrl_checks.sv */
//--------------------------------------------------------------------------
// concurrent assertions on the controller's inputs and outputs
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "pwo_defines.svh"

module pwo_ctrl_checks import pwo_pkg::*; (
  input logic  pi_clk,
  input logic  pi_reset_n,
  input logic  zeroize,
  input logic  enable,
  input mode_t mode,
  input logic  accumulate,
  input logic  sampler_valid,
  input logic  rd_en,
  input logic  wr_en,
  input logic  busy,
  input logic  done
);

  localparam int LAT = `PWO_WR_LAT;
  localparam int CNT_W = $clog2(`PWO_N) + 1;

  logic [LAT-1:0]   rd_line;
  logic [CNT_W-1:0] samp_cnt;

  // rd_en history, oldest at the top
  always_ff @(posedge pi_clk or negedge pi_reset_n) begin
    if (!pi_reset_n) begin
      rd_line <= '0;
    end else if (zeroize) begin
      rd_line <= '0;
    end else begin
      rd_line <= {rd_line[LAT-2:0], rd_en};
    end
  end

  // sampler words taken by the current pwm operation
  always_ff @(posedge pi_clk or negedge pi_reset_n) begin
    if (!pi_reset_n) begin
      samp_cnt <= '0;
    end else if (zeroize || done) begin
      samp_cnt <= '0;
    end else if (rd_en && sampler_valid && (mode == pwm)) begin
      samp_cnt <= samp_cnt + 1'b1;
    end
  end

  default clocking chk_clk @(posedge pi_clk); endclocking

  wr_follows_rd: assert property (disable iff (!pi_reset_n || zeroize)
    wr_en == rd_line[LAT-1]);

  mode_stable: assert property (disable iff (!pi_reset_n || zeroize)
    busy |-> $stable(mode) && $stable(accumulate));

  acc_only_pwm: assert property (disable iff (!pi_reset_n)
    (enable || busy) && accumulate |-> (mode == pwm));

  sampler_limit: assert property (disable iff (!pi_reset_n || zeroize)
    (samp_cnt == CNT_W'(`PWO_N)) |-> !(rd_en && sampler_valid));

  done_ends_busy: assert property (disable iff (!pi_reset_n || zeroize)
    done |-> !busy && $past(busy));

endmodule

/* pwo_mem.sv */
//--------------------------------------------------------------------------
// coefficient memory with three registered read ports, one write port,
// host access while idle and zeroize clear
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "pwo_defines.svh"

module pwo_mem import pwo_pkg::*; (
  input  logic  pi_clk,
  input  logic  pi_reset_n,
  input  logic  zeroize,
  input  logic  rd_en,
  input  addr_t rd_addr_a,
  input  addr_t rd_addr_b,
  input  addr_t rd_addr_c,
  input  logic  wr_en,
  input  addr_t wr_addr,
  input  coef_t result,
  input  logic  host_wr_en,
  input  addr_t host_addr,
  input  coef_t host_wr_data,
  input  logic  busy,
  output coef_t rd_data_a,
  output coef_t rd_data_b,
  output coef_t rd_data_c,
  output coef_t host_rd_data
);

  localparam int DEPTH = 1 << `PWO_ADDR_W;

  coef_t mem [DEPTH];
  logic  a_en;
  addr_t a_addr;
  logic  we;
  addr_t w_addr;
  coef_t w_data;

  // host owns port a and the write port while idle
  assign a_en   = busy ? rd_en : 1'b1;
  assign a_addr = busy ? rd_addr_a : host_addr;
  assign we     = busy ? wr_en : host_wr_en;
  assign w_addr = busy ? wr_addr : host_addr;
  assign w_data = busy ? result : host_wr_data;

  always_ff @(posedge pi_clk) begin
    if (zeroize) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (we) begin
      mem[w_addr] <= w_data;
    end
  end

  always_ff @(posedge pi_clk or negedge pi_reset_n) begin
    if (!pi_reset_n) begin
      rd_data_a <= '0;
      rd_data_b <= '0;
      rd_data_c <= '0;
    end else begin
      if (a_en) begin
        rd_data_a <= mem[a_addr];
      end
      if (rd_en) begin
        rd_data_b <= mem[rd_addr_b];
        rd_data_c <= mem[rd_addr_c];
      end
    end
  end

  assign host_rd_data = rd_data_a;

endmodule

/* pwo_arith.sv */
//--------------------------------------------------------------------------
// four-stage modular multiply, add, subtract and accumulate pipeline
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "pwo_defines.svh"

module pwo_arith import pwo_pkg::*; (
  input  logic  pi_clk,
  input  logic  pi_reset_n,
  input  logic  zeroize,
  input  mode_t mode,
  input  logic  accumulate,
  input  logic  rd_en,
  input  logic  issue_b_sel,
  input  coef_t sampler_data,
  input  coef_t rd_data_a,
  input  coef_t rd_data_b,
  input  coef_t rd_data_c,
  output coef_t result,
  output logic  result_valid
);

  localparam int PW = 2 * `PWO_COEF_W;
  localparam int SW = `PWO_COEF_W + 1;

  logic          v0, v1, v2, v3;
  logic          bsel0;
  coef_t         samp0;
  coef_t         a1, b1, c1;
  coef_t         c2, c3;
  coef_t         r3;
  logic [PW-1:0] wide2;
  logic          acc_en;
  logic [SW-1:0] acc_sum;

  // valid line from the issue cycle to the result
  always_ff @(posedge pi_clk or negedge pi_reset_n) begin
    if (!pi_reset_n) begin
      {v0, v1, v2, v3, result_valid} <= '0;
    end else if (zeroize) begin
      {v0, v1, v2, v3, result_valid} <= '0;
    end else begin
      {v0, v1, v2, v3, result_valid} <= {rd_en, v0, v1, v2, v3};
    end
  end

  // sampler word is held while the memory read is in flight
  always_ff @(posedge pi_clk) begin
    bsel0 <= issue_b_sel;
    if (rd_en) begin
      samp0 <= sampler_data;
    end
  end

  assign acc_en = accumulate && (mode == pwm);

  // operand regs, product or sum, mod q, accumulate
  always_ff @(posedge pi_clk) begin
    a1 <= rd_data_a;
    b1 <= bsel0 ? samp0 : rd_data_b;
    c1 <= rd_data_c;
    c2 <= c1;
    case (mode)
      pwm:     wide2 <= PW'(a1) * PW'(b1);
      pwa:     wide2 <= PW'(a1) + PW'(b1);
      // q added first keeps the difference positive
      default: wide2 <= PW'(a1) + PW'(`PWO_Q) - PW'(b1);
    endcase
    r3 <= coef_t'(wide2 % PW'(`PWO_Q));
    c3 <= c2;
    if (acc_sum >= SW'(`PWO_Q)) begin
      result <= coef_t'(acc_sum - SW'(`PWO_Q));
    end else begin
      result <= coef_t'(acc_sum);
    end
  end

  assign acc_sum = SW'(r3) + (acc_en ? SW'(c3) : SW'(0));

  result_in_range: assert property (
    @(posedge pi_clk) disable iff (!pi_reset_n)
    result_valid |-> (result < `PWO_Q)
  );

endmodule

/* pwo_ctrl.sv */
//--------------------------------------------------------------------------
// operation FSM, issue and write indices, memory address generation,
// busy and done
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "pwo_defines.svh"

module pwo_ctrl import pwo_pkg::*; (
  input  logic  pi_clk,
  input  logic  pi_reset_n,
  input  logic  zeroize,
  input  logic  enable,
  input  mode_t mode,
  input  addr_t base_a,
  input  addr_t base_b,
  input  addr_t base_c,
  input  logic  sampler_valid,
  output logic  rd_en,
  output addr_t rd_addr_a,
  output addr_t rd_addr_b,
  output addr_t rd_addr_c,
  output addr_t wr_addr,
  output logic  issue_b_sel,
  output logic  busy,
  output logic  done
);

  localparam int IDX_W = $clog2(`PWO_N);
  localparam int LAT = `PWO_WR_LAT;

  typedef enum logic {
    st_idle,
    st_exec
  } state_t;

  state_t                    state;
  logic [IDX_W:0]            iss_cnt;
  logic                      issue_open;
  logic                      last_wr;
  logic [LAT-1:0]            line_v;
  logic [LAT-1:0][IDX_W-1:0] line_idx;
  addr_t                     base_a_q;
  addr_t                     base_b_q;
  addr_t                     base_c_q;
  addr_t                     iss_off;
  addr_t                     wr_off;

  //------------------------------------------------------------------------
  // issue side
  //------------------------------------------------------------------------

  // still indices left to read in this operation
  assign issue_open = (state == st_exec) && (iss_cnt < (IDX_W+1)'(`PWO_N));

  // pwm stalls on the sampler, add and subtract read every cycle
  assign rd_en = issue_open && ((mode != pwm) || sampler_valid);

  assign issue_b_sel = (mode == pwm);

  assign iss_off   = addr_t'(iss_cnt[IDX_W-1:0]);
  assign rd_addr_a = base_a_q + iss_off;
  assign rd_addr_b = base_b_q + iss_off;
  assign rd_addr_c = base_c_q + iss_off;

  // bases are captured when the operation starts
  always_ff @(posedge pi_clk) begin
    if ((state == st_idle) && enable) begin
      base_a_q <= base_a;
      base_b_q <= base_b;
      base_c_q <= base_c;
    end
  end

  //------------------------------------------------------------------------
  // write side
  //------------------------------------------------------------------------

  // issued index travels alongside the data to the write stage
  always_ff @(posedge pi_clk or negedge pi_reset_n) begin
    if (!pi_reset_n) begin
      line_v <= '0;
    end else if (zeroize) begin
      line_v <= '0;
    end else begin
      line_v <= {line_v[LAT-2:0], rd_en};
    end
  end

  always_ff @(posedge pi_clk) begin
    line_idx <= {line_idx[LAT-2:0], iss_cnt[IDX_W-1:0]};
  end

  assign wr_off  = addr_t'(line_idx[LAT-1]);
  assign wr_addr = base_c_q + wr_off;
  assign last_wr = line_v[LAT-1] && (line_idx[LAT-1] == IDX_W'(`PWO_N - 1));

  //------------------------------------------------------------------------
  // operation FSM
  //------------------------------------------------------------------------
  always_ff @(posedge pi_clk or negedge pi_reset_n) begin
    if (!pi_reset_n) begin
      state   <= st_idle;
      iss_cnt <= '0;
      done    <= 1'b0;
    end else if (zeroize) begin
      state   <= st_idle;
      iss_cnt <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        st_idle: begin
          if (enable) begin
            state   <= st_exec;
            iss_cnt <= '0;
          end
        end
        st_exec: begin
          if (rd_en) begin
            iss_cnt <= iss_cnt + 1'b1;
          end
          // done follows the final write by one cycle
          if (last_wr) begin
            state <= st_idle;
            done  <= 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  assign busy = (state == st_exec);

  // every read is issued before the final write lands
  reads_done_at_last_wr: assert property (
    @(posedge pi_clk) disable iff (!pi_reset_n || zeroize)
    last_wr |-> (iss_cnt == (IDX_W+1)'(`PWO_N))
  );

endmodule

/* pwo_pkg.sv */
//--------------------------------------------------------------------------
// operation mode, coefficient and address types
//--------------------------------------------------------------------------
`include "pwo_defines.svh"

package pwo_pkg;

  // pointwise multiply, add and subtract
  typedef enum logic [1:0] {
    pwm = 2'd0,
    pwa = 2'd1,
    pws = 2'd2
  } mode_t;

  // one coefficient modulo q
  typedef logic [`PWO_COEF_W-1:0] coef_t;

  // word address in the coefficient memory
  typedef logic [`PWO_ADDR_W-1:0] addr_t;

endpackage

/* pwo_defines.svh */
//--------------------------------------------------------------------------
// modulus, widths, polynomial length and pipeline latencies for the
// pointwise-operation engine
//--------------------------------------------------------------------------
`ifndef PWO_DEFINES_SVH
`define PWO_DEFINES_SVH

// prime modulus of the coefficient ring
`define PWO_Q 23'd8380417

// one coefficient fits in 23 bits
`define PWO_COEF_W 23

// 256 memory words
`define PWO_ADDR_W 8

// coefficients per polynomial
`define PWO_N 64

// operand register, product, reduction, accumulate
`define PWO_ARITH_LAT 4

// memory read plus arithmetic pipeline
`define PWO_WR_LAT 5

`endif
